// ==== dps_config.svh ====
`ifndef DPS_CONFIG_SVH
`define DPS_CONFIG_SVH

// Interrupt table, entry 0 is the timer and entry 1 the flags
`define DPS_IRQ_SOURCES 2
`define DPS_IRQ_ENTRY_W 6	// Entry index width

// Compare timer
`define DPS_UTIM_W 64

// Low-speed status flags
`define DPS_LS_FLAGS 4

`endif

// ==== dps_irq.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dps_config.svh"

module dps_irq import dps_pkg::*; (
	input  logic       iCLOCK,
	input  logic       inRESET,
	input  irq_table_t table_cfg,
	// Source requests and accepts
	input  logic       tim_irq,
	input  logic       ls_irq,
	output logic       tim_ack,
	output logic       ls_ack,
	// Processor side
	output irq_out_t   irq,
	input  logic       irq_ack
);

	localparam int ENT_TIM = 0;
	localparam int ENT_LS  = `DPS_IRQ_SOURCES - 1;	// Flags use the last entry

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_WAIT = 1'b1
	} irq_state_t;

	irq_state_t b_state;
	irq_src_t   b_num;
	logic       tim_pass;
	logic       ls_pass;
	logic       idle;

	// Invalid entry lets the source through, valid needs the mask bit
	assign tim_pass = tim_irq && (!table_cfg[ENT_TIM].valid || table_cfg[ENT_TIM].mask);
	assign ls_pass  = ls_irq && (!table_cfg[ENT_LS].valid || table_cfg[ENT_LS].mask);

	assign idle = (b_state == ST_IDLE);

	// Timer wins over the flags
	assign tim_ack = idle && tim_pass;
	assign ls_ack  = idle && ls_pass && !tim_pass;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state <= ST_IDLE;
			b_num   <= SRC_LS;
		end
		else begin
			case (b_state)
				ST_IDLE: begin
					if (tim_ack || ls_ack) begin
						b_state <= ST_WAIT;
						b_num   <= tim_ack ? SRC_TIMER : SRC_LS;	// Winner of this cycle
					end
				end
				ST_WAIT: begin
					if (irq_ack) begin
						b_state <= ST_IDLE;
					end
				end
				default: b_state <= ST_IDLE;
			endcase
		end
	end

	assign irq.valid = (b_state == ST_WAIT);
	assign irq.num   = b_num;

	a_one_ack: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(tim_ack && ls_ack)
	) else $error("both sources accepted in one cycle");

	// Sources must stay pending while the processor is busy
	a_no_ack_busy: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		irq.valid |-> !(tim_ack || ls_ack)
	) else $error("accept strobe while interrupt outstanding");

	a_hold_valid: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(irq.valid && !irq_ack) |=> (irq.valid && $stable(irq.num))
	) else $error("interrupt output dropped before acknowledge");

endmodule

`default_nettype wire

// ==== dps_irq_table.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dps_config.svh"

module dps_irq_table import dps_pkg::*; (
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	// Write strobe
	input  logic                        cfg_wr_req,
	input  irq_cfg_wr_t                 cfg_wr,
	// Read port
	input  logic [`DPS_IRQ_ENTRY_W-1:0] cfg_rd_entry,
	output irq_cfg_t                    cfg_rd_data,
	// Entries towards the controller
	output irq_table_t                  table_cfg
);

	irq_table_t b_table;

	// Writes past the last source fall through every compare
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_table <= '0;
		end
		else if (cfg_wr_req) begin
			for (int i = 0; i < `DPS_IRQ_SOURCES; i++) begin
				if (cfg_wr.entry == `DPS_IRQ_ENTRY_W'(i)) begin
					b_table[i] <= cfg_wr.cfg;
				end
			end
		end
	end

	// Combinational read, unknown entries give zero
	always_comb begin
		cfg_rd_data = '0;
		for (int i = 0; i < `DPS_IRQ_SOURCES; i++) begin
			if (cfg_rd_entry == `DPS_IRQ_ENTRY_W'(i)) begin
				cfg_rd_data = b_table[i];
			end
		end
	end

	assign table_cfg = b_table;

	// A write leaves every other entry alone
	genvar g;
	generate
		for (g = 0; g < `DPS_IRQ_SOURCES; g++) begin : g_entry_chk
			property p_other_entry_stable;
				@(posedge iCLOCK) disable iff (!inRESET)
				(cfg_wr_req && (cfg_wr.entry != `DPS_IRQ_ENTRY_W'(g)))
					|=> $stable(b_table[g]);
			endproperty

			a_other_entry_stable: assert property (p_other_entry_stable)
				else $error("table entry %0d changed by write to another entry", g);
		end
	endgenerate

endmodule

`default_nettype wire

// ==== dps_lsflags.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dps_config.svh"

module dps_lsflags import dps_pkg::*; (
	input  logic    iCLOCK,
	input  logic    inRESET,
	input  ls_vec_t ls_event,	// Raw event pulses
	input  ls_vec_t ls_enable,
	output ls_vec_t ls_flags,
	// Request towards the controller
	output logic    ls_irq,
	input  logic    ls_ack
);

	ls_vec_t b_flags;
	ls_vec_t flags_next;

	// Accept wipes what is set, events of the same cycle stay
	assign flags_next = (b_flags & ~{`DPS_LS_FLAGS{ls_ack}}) | ls_event;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_flags <= '0;
		end
		else begin
			b_flags <= flags_next;
		end
	end

	assign ls_flags = b_flags;
	assign ls_irq   = |(b_flags & ls_enable);	// Enabled flags only

	// Controller must not accept an idle flag block
	a_ack_needs_req: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		ls_ack |-> ls_irq
	) else $error("flags accepted without a request");

endmodule

`default_nettype wire

// ==== dps_pkg.sv ====
`include "dps_config.svh"

package dps_pkg;

	// Source number as seen on the interrupt output
	typedef enum logic [0:0] {
		SRC_LS    = 1'b0,
		SRC_TIMER = 1'b1
	} irq_src_t;

	// One configuration table entry
	typedef struct packed {
		logic       mask;
		logic       valid;
		logic [1:0] level;	// Stored for software only
	} irq_cfg_t;

	// Table write from the processor side
	typedef struct packed {
		logic [`DPS_IRQ_ENTRY_W-1:0] entry;
		irq_cfg_t                    cfg;
	} irq_cfg_wr_t;

	// Whole table, one entry per source
	typedef irq_cfg_t [`DPS_IRQ_SOURCES-1:0] irq_table_t;

	// Interrupt line towards the processor
	typedef struct packed {
		logic     valid;
		irq_src_t num;
	} irq_out_t;

	typedef logic [`DPS_UTIM_W-1:0]   utim_t;
	typedef logic [`DPS_LS_FLAGS-1:0] ls_vec_t;

endpackage

// ==== dps_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dps_config.svh"

module dps_top import dps_pkg::*; (
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	// Configuration table
	input  logic                        cfg_wr_req,
	input  irq_cfg_wr_t                 cfg_wr,
	input  logic [`DPS_IRQ_ENTRY_W-1:0] cfg_rd_entry,
	output irq_cfg_t                    cfg_rd_data,
	// Timer
	input  logic                        tim_enable,
	input  logic                        tim_cmp_req,
	input  logic [`DPS_UTIM_W-1:0]      tim_cmp_value,
	output utim_t                       tim_count,
	// Status flags
	input  ls_vec_t                     ls_event,
	input  ls_vec_t                     ls_enable,
	output ls_vec_t                     ls_flags,
	// Processor interrupt
	output irq_out_t                    irq,
	input  logic                        irq_ack
);

	irq_table_t table_cfg;
	logic       tim_irq;
	logic       tim_ack;
	logic       ls_irq;
	logic       ls_ack;

	dps_irq_table u_table (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.cfg_wr_req   (cfg_wr_req),
		.cfg_wr       (cfg_wr),
		.cfg_rd_entry (cfg_rd_entry),
		.cfg_rd_data  (cfg_rd_data),
		.table_cfg    (table_cfg)
	);

	dps_irq u_irq (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.table_cfg (table_cfg),
		.tim_irq   (tim_irq),
		.ls_irq    (ls_irq),
		.tim_ack   (tim_ack),
		.ls_ack    (ls_ack),
		.irq       (irq),
		.irq_ack   (irq_ack)
	);

	// Entry 0 source
	dps_utim64 u_utim64 (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.tim_enable    (tim_enable),
		.tim_cmp_req   (tim_cmp_req),
		.tim_cmp_value (tim_cmp_value),
		.tim_count     (tim_count),
		.tim_irq       (tim_irq),
		.tim_ack       (tim_ack)
	);

	// Entry 1 source
	dps_lsflags u_lsflags (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.ls_event  (ls_event),
		.ls_enable (ls_enable),
		.ls_flags  (ls_flags),
		.ls_irq    (ls_irq),
		.ls_ack    (ls_ack)
	);

endmodule

`default_nettype wire

// ==== dps_utim64.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dps_config.svh"

module dps_utim64 import dps_pkg::*; (
	input  logic                   iCLOCK,
	input  logic                   inRESET,
	input  logic                   tim_enable,
	// Compare load
	input  logic                   tim_cmp_req,
	input  logic [`DPS_UTIM_W-1:0] tim_cmp_value,
	output utim_t                  tim_count,
	// Request towards the controller
	output logic                   tim_irq,
	input  logic                   tim_ack
);

	utim_t b_count;
	utim_t b_cmp;
	logic  b_pending;
	logic  match;

	// Only an enabled counter can hit the compare value
	assign match = tim_enable && (b_count == b_cmp);

	// Free-running up counter
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_count <= '0;
		end
		else if (tim_enable) begin
			b_count <= b_count + `DPS_UTIM_W'd1;
		end
	end

	// Compare register
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_cmp <= '1;	// Far away so nothing matches before the first load
		end
		else if (tim_cmp_req) begin
			b_cmp <= tim_cmp_value;
		end
	end

	// Pending request, a new match beats the accept
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_pending <= 1'b0;
		end
		else if (match) begin
			b_pending <= 1'b1;
		end
		else if (tim_ack) begin
			b_pending <= 1'b0;
		end
	end

	assign tim_count = b_count;
	assign tim_irq   = b_pending;

	// The controller only accepts a timer that is asking
	a_ack_needs_req: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		tim_ack |-> tim_irq
	) else $error("timer accepted without a request");

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
dps_pkg.sv
dps_irq_table.sv
dps_irq.sv
dps_utim64.sv
dps_lsflags.sv
dps_top.sv
tb_dps.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_dps \
	-f project.f

# The simulation's own exit status is not trusted, the log decides
./obj_dir/Vtb_dps | tee sim.log || true

if grep -q "Done: no errors" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== tb_dps.sv ====
`timescale 1ns/100ps
`include "dps_config.svh"

module tb_dps import dps_pkg::*; ();

	// Rough cycle budget per test
	localparam int T_RESET  = 4;
	localparam int T_TABLE  = 60;
	localparam int T_TIMER  = 60;
	localparam int T_GATING = 80;
	localparam int T_PRIO   = 150;
	localparam int T_FLAGS  = 100;
	localparam int CYCLE_LIMIT = T_RESET + T_TABLE + T_TIMER + T_GATING + T_PRIO + T_FLAGS + 100;

	// Inputs as the DUT sees them at a clock edge
	typedef struct packed {
		logic        cfg_wr_req;
		irq_cfg_wr_t cfg_wr;
		logic        tim_enable;
		logic        tim_cmp_req;
		utim_t       tim_cmp_value;
		ls_vec_t     ls_event;
		ls_vec_t     ls_enable;
		logic        irq_ack;
	} stim_t;

	// Expected state of the subsystem
	typedef struct packed {
		irq_table_t tbl;
		utim_t      count;
		utim_t      cmp;
		logic       pending;
		ls_vec_t    flags;
		logic       busy;	// Interrupt outstanding
		irq_src_t   num;
	} model_t;

	logic                        iCLOCK;
	logic                        inRESET;
	logic                        cfg_wr_req;
	irq_cfg_wr_t                 cfg_wr;
	logic [`DPS_IRQ_ENTRY_W-1:0] cfg_rd_entry;
	irq_cfg_t                    cfg_rd_data;
	logic                        tim_enable;
	logic                        tim_cmp_req;
	utim_t                       tim_cmp_value;
	utim_t                       tim_count;
	ls_vec_t                     ls_event;
	ls_vec_t                     ls_enable;
	ls_vec_t                     ls_flags;
	irq_out_t                    irq;
	logic                        irq_ack;

	stim_t       stim;
	model_t      model;
	logic [15:0] lfsr;
	int          cycles;
	int          errors;
	int          checks;
	int          tests;

	dps_top dut (.*);

	always #20 iCLOCK = ~iCLOCK;

	assign stim = {cfg_wr_req, cfg_wr, tim_enable, tim_cmp_req, tim_cmp_value,
		ls_event, ls_enable, irq_ack};

	// Galois LFSR, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic model_t reset_state();
		model_t m;
		m = '0;
		m.cmp = '1;	// No match before the first compare load
		return m;
	endfunction

	// One clock edge of the subsystem rules
	function automatic model_t next_state(input model_t m, input stim_t s);
		model_t n;
		logic   tim_go;
		logic   ls_go;
		logic   tim_take;
		logic   ls_take;
		n = m;
		// Entry not valid, or valid with mask set, lets a source through
		tim_go = m.pending && (!m.tbl[0].valid || m.tbl[0].mask);
		ls_go = (|(m.flags & s.ls_enable)) && (!m.tbl[1].valid || m.tbl[1].mask);
		tim_take = !m.busy && tim_go;
		ls_take = !m.busy && ls_go && !tim_go;	// Timer first
		if (s.cfg_wr_req && (s.cfg_wr.entry < 6'(`DPS_IRQ_SOURCES))) begin
			n.tbl[s.cfg_wr.entry[0]] = s.cfg_wr.cfg;
		end
		if (s.tim_enable) begin
			n.count = m.count + 64'd1;
		end
		if (s.tim_cmp_req) begin
			n.cmp = s.tim_cmp_value;
		end
		if (s.tim_enable && (m.count == m.cmp)) begin
			n.pending = 1'b1;
		end
		else if (tim_take) begin
			n.pending = 1'b0;
		end
		n.flags = (ls_take ? 4'h0 : m.flags) | s.ls_event;
		if (m.busy) begin
			if (s.irq_ack) begin
				n.busy = 1'b0;
			end
		end
		else if (tim_take || ls_take) begin
			n.busy = 1'b1;
			n.num = tim_take ? SRC_TIMER : SRC_LS;
		end
		return n;
	endfunction

	function automatic irq_cfg_t read_entry(input model_t m, input logic [5:0] e);
		if (e < 6'(`DPS_IRQ_SOURCES)) begin
			return m.tbl[e[0]];
		end
		return '0;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cycles);
		end
	endtask

	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			model <= reset_state();
		end
		else begin
			model <= next_state(model, stim);
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge iCLOCK) begin
		check_value("irq", 64'(irq), 64'({model.busy, model.num}));
		check_value("cfg_rd_data", 64'(cfg_rd_data), 64'(read_entry(model, cfg_rd_entry)));
		check_value("tim_count", tim_count, model.count);
		check_value("ls_flags", 64'(ls_flags), 64'(model.flags));
	end

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge iCLOCK);
	endtask

	task automatic write_cfg(input logic [5:0] entry, input irq_cfg_t cfg);
		@(posedge iCLOCK);
		cfg_wr_req <= 1'b1;
		cfg_wr.entry <= entry;
		cfg_wr.cfg <= cfg;
		@(posedge iCLOCK);
		cfg_wr_req <= 1'b0;
	endtask

	task automatic load_compare(input utim_t offset);
		@(posedge iCLOCK);
		tim_cmp_req <= 1'b1;
		tim_cmp_value <= model.count + offset;	// Ahead of the running count
		@(posedge iCLOCK);
		tim_cmp_req <= 1'b0;
	endtask

	task automatic pulse_event(input ls_vec_t ev);
		@(posedge iCLOCK);
		ls_event <= ev;
		@(posedge iCLOCK);
		ls_event <= '0;
	endtask

	task automatic wait_valid(input irq_src_t num);
		do begin
			@(negedge iCLOCK);
		end while (irq.valid !== 1'b1);
		check_value("irq.num", 64'(irq.num), 64'(num));
	endtask

	task automatic ack_irq(input int delay);
		idle_cycles(delay);
		@(posedge iCLOCK);
		irq_ack <= 1'b1;
		@(posedge iCLOCK);
		irq_ack <= 1'b0;
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	task automatic table_readback();
		int          err0;
		logic [63:0] r;
		err0 = errors;
		for (int i = 0; i < 4; i++) begin
			@(posedge iCLOCK);
			cfg_rd_entry <= 6'(i);
			@(negedge iCLOCK);
			check_value("cfg_rd_data", 64'(cfg_rd_data), 64'd0);	// Reset contents
		end
		for (int i = 0; i < 48; i++) begin
			r = rand_bits(20);
			@(posedge iCLOCK);
			cfg_wr_req <= r[0];
			cfg_wr.entry <= r[1] ? {5'd0, r[2]} : r[8:3];
			cfg_wr.cfg <= r[12:9];
			cfg_rd_entry <= r[13] ? {5'd0, r[14]} : r[19:14];
		end
		@(posedge iCLOCK);
		cfg_wr_req <= 1'b0;
		report_test("table", err0);
	endtask

	task automatic timer_interrupt();
		int          err0;
		logic [63:0] r;
		err0 = errors;
		r = rand_bits(7);
		write_cfg(6'd0, {1'b0, 1'b0, r[1:0]});	// Invalid entry passes
		@(posedge iCLOCK);
		tim_enable <= 1'b1;
		load_compare(64'd4 + {59'd0, r[6:2]});
		wait_valid(SRC_TIMER);
		ack_irq(int'(rand_bits(3)));
		report_test("timer", err0);
	endtask

	task automatic source_gating();
		int          err0;
		logic [63:0] r;
		err0 = errors;
		r = rand_bits(12);
		write_cfg(6'd0, {1'b0, 1'b1, r[1:0]});
		load_compare(64'd5);
		idle_cycles(12);
		@(negedge iCLOCK);
		check_value("irq.valid", 64'(irq.valid), 64'd0);
		write_cfg(6'd0, {1'b1, 1'b1, r[3:2]});	// Mask opens the gate
		wait_valid(SRC_TIMER);
		ack_irq(int'(r[6:4]));
		write_cfg(6'd1, {1'b0, 1'b1, r[1:0]});
		@(posedge iCLOCK);
		ls_enable <= 4'hF;
		pulse_event({r[9:7], 1'b1});
		idle_cycles(10);
		@(negedge iCLOCK);
		check_value("irq.valid", 64'(irq.valid), 64'd0);
		write_cfg(6'd1, {1'b0, 1'b0, r[1:0]});	// Clearing valid opens it too
		wait_valid(SRC_LS);
		ack_irq(int'(r[11:10]));
		report_test("gating", err0);
	endtask

	task automatic priority_order();
		int          err0;
		logic [63:0] r;
		err0 = errors;
		write_cfg(6'd0, {1'b1, 1'b1, 2'd3});
		write_cfg(6'd1, {1'b0, 1'b0, 2'd1});
		@(posedge iCLOCK);
		ls_enable <= 4'hF;
		for (int i = 0; i < 3; i++) begin
			r = rand_bits(12);
			pulse_event({r[2:0], 1'b1});
			wait_valid(SRC_LS);
			// Both sources pend behind the outstanding interrupt
			load_compare(64'd6);
			pulse_event({r[5:3], 1'b1});
			idle_cycles(8);
			@(negedge iCLOCK);
			check_value("irq.num", 64'(irq.num), 64'(SRC_LS));
			ack_irq(int'(r[7:6]));
			wait_valid(SRC_TIMER);
			ack_irq(int'(r[9:8]));
			wait_valid(SRC_LS);
			ack_irq(int'(r[11:10]));
		end
		report_test("priority", err0);
	endtask

	task automatic flag_events();
		int          err0;
		logic [63:0] r;
		err0 = errors;
		@(posedge iCLOCK);
		ls_enable <= 4'b0011;
		@(posedge iCLOCK);
		ls_event <= 4'b0001;
		@(posedge iCLOCK);
		ls_event <= 4'b0010;	// Lands in the accept cycle of flag 0
		@(posedge iCLOCK);
		ls_event <= 4'b0000;
		@(negedge iCLOCK);
		check_value("ls_flags", 64'(ls_flags), 64'h2);
		wait_valid(SRC_LS);
		ack_irq(0);
		wait_valid(SRC_LS);
		ack_irq(1);
		for (int i = 0; i < 64; i++) begin
			r = rand_bits(16);
			@(posedge iCLOCK);
			ls_event <= r[3:0] & r[7:4];	// Sparse pulses
			if (r[10:8] == 3'd0) begin
				ls_enable <= r[14:11];
			end
			irq_ack <= irq.valid && !irq_ack && r[15];
		end
		@(posedge iCLOCK);
		ls_event <= '0;
		irq_ack <= 1'b0;
		@(negedge iCLOCK);
		if (irq.valid) begin
			ack_irq(0);
		end
		report_test("flags", err0);
	endtask

	initial begin
		iCLOCK = 1'b0;
		lfsr = 16'd63302;
		inRESET <= 1'b0;
		cfg_wr_req <= 1'b0;
		cfg_wr <= '0;
		cfg_rd_entry <= '0;
		tim_enable <= 1'b0;
		tim_cmp_req <= 1'b0;
		tim_cmp_value <= '0;
		ls_event <= '0;
		ls_enable <= '0;
		irq_ack <= 1'b0;
		repeat (T_RESET) @(posedge iCLOCK);
		inRESET <= 1'b1;
		table_readback();
		timer_interrupt();
		source_gating();
		priority_order();
		flag_events();
		idle_cycles(2);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end
		else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
